// File: Makefile
# Verilator build for the axi tlb testbench

VERILATOR ?= verilator
LINT_FLAGS = --lint-only --timing --assert
SIM_FLAGS = --binary --assert -j 0
TOP = tb_axi_tlb
FILELIST = project.f
OBJ_DIR = obj_dir
PASS_MSG = *** PASSED ***

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# the run passes only if the pass message shows up in the output
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -F -- '$(PASS_MSG)' > /dev/null

clean:
	rm -rf $(OBJ_DIR)

// File: axi_tlb.sv
// axi read translation unit, read manager and walker sharing one physical read port
module axi_tlb #(
	parameter logic [axi_tlb_pkg::APP_ID_W-1:0] APP_ID = '0,
	parameter int LOG_DEPTH = 5
) (
	input logic clk,
	input logic rst,

	input axi_tlb_pkg::ar_req_t ar,
	input logic ar_valid,
	output logic ar_ready,
	output axi_tlb_pkg::r_beat_t r,
	output logic r_valid,
	input logic r_ready,

	output axi_tlb_pkg::ar_req_t phys_ar,
	output logic phys_ar_valid,
	input logic phys_ar_ready,
	input axi_tlb_pkg::r_beat_t phys_r,
	input logic phys_r_valid,
	output logic phys_r_ready
);

	axi_tlb_pkg::tlb_req_t tlb_req;
	logic tlb_req_valid;
	logic tlb_req_ready;
	axi_tlb_pkg::tlb_resp_t tlb_resp;
	logic tlb_resp_valid;
	logic tlb_resp_ready;

	axi_tlb_pkg::ar_req_t mgr_ar;
	logic mgr_ar_valid;
	logic mgr_ar_ready;
	axi_tlb_pkg::r_beat_t mgr_r;
	logic mgr_r_valid;
	logic mgr_r_ready;

	axi_tlb_pkg::ar_req_t walk_ar;
	logic walk_ar_valid;
	logic walk_ar_ready;
	axi_tlb_pkg::r_beat_t walk_r;
	logic walk_r_valid;
	logic walk_r_ready;

	read_mgr #(.LOG_DEPTH(LOG_DEPTH)) u_read_mgr (
		.clk(clk), .rst(rst),
		.ar(ar), .ar_valid(ar_valid), .ar_ready(ar_ready),
		.r(r), .r_valid(r_valid), .r_ready(r_ready),
		.tlb_req(tlb_req), .tlb_req_valid(tlb_req_valid), .tlb_req_ready(tlb_req_ready),
		.tlb_resp(tlb_resp), .tlb_resp_valid(tlb_resp_valid), .tlb_resp_ready(tlb_resp_ready),
		.mem_ar(mgr_ar), .mem_ar_valid(mgr_ar_valid), .mem_ar_ready(mgr_ar_ready),
		.mem_r(mgr_r), .mem_r_valid(mgr_r_valid), .mem_r_ready(mgr_r_ready)
	);

	tlb_walker #(.APP_ID(APP_ID), .LOG_DEPTH(LOG_DEPTH)) u_walker (
		.clk(clk), .rst(rst),
		.tlb_req(tlb_req), .tlb_req_valid(tlb_req_valid), .tlb_req_ready(tlb_req_ready),
		.tlb_resp(tlb_resp), .tlb_resp_valid(tlb_resp_valid), .tlb_resp_ready(tlb_resp_ready),
		.pte_ar(walk_ar), .pte_ar_valid(walk_ar_valid), .pte_ar_ready(walk_ar_ready),
		.pte_r(walk_r), .pte_r_valid(walk_r_valid), .pte_r_ready(walk_r_ready)
	);

	phys_read_arb u_arb (
		.walk_ar(walk_ar), .walk_ar_valid(walk_ar_valid), .walk_ar_ready(walk_ar_ready),
		.walk_r(walk_r), .walk_r_valid(walk_r_valid), .walk_r_ready(walk_r_ready),
		.mgr_ar(mgr_ar), .mgr_ar_valid(mgr_ar_valid), .mgr_ar_ready(mgr_ar_ready),
		.mgr_r(mgr_r), .mgr_r_valid(mgr_r_valid), .mgr_r_ready(mgr_r_ready),
		.phys_ar(phys_ar), .phys_ar_valid(phys_ar_valid), .phys_ar_ready(phys_ar_ready),
		.phys_r(phys_r), .phys_r_valid(phys_r_valid), .phys_r_ready(phys_r_ready)
	);

endmodule

// File: axi_tlb_pkg.sv
// axi tlb shared widths, channel structs and the two views of a returned read word
package axi_tlb_pkg;

	localparam int ADDR_W = 64;
	localparam int PAGE_OFS_W = 12;
	localparam int VPN_W = ADDR_W - PAGE_OFS_W;
	localparam int ID_W = 16;
	localparam int LEN_W = 8;
	localparam int SIZE_W = 3;
	localparam int RESP_W = 2;
	localparam int DATA_W = 512;
	localparam int PTE_W = 64;
	localparam int PTES_PER_LINE = DATA_W / PTE_W;
	localparam int APP_ID_W = 2;
	// pte field widths
	localparam int PTE_TAG_W = 36;
	localparam int PTE_PPN_W = 24;

	localparam logic [RESP_W-1:0] RESP_OKAY = 2'b00;
	localparam logic [RESP_W-1:0] RESP_SLVERR = 2'b10;
	// 64 bytes per beat
	localparam logic [SIZE_W-1:0] PTE_LINE_SIZE = 3'b110;

	typedef struct packed {
		logic [ID_W-1:0] id;
		logic [ADDR_W-1:0] addr;
		logic [LEN_W-1:0] len;
		logic [SIZE_W-1:0] size;
	} ar_req_t;

	typedef struct packed {
		logic [ID_W-1:0] id;
		logic [DATA_W-1:0] data;
		logic [RESP_W-1:0] resp;
		logic last;
	} r_beat_t;

	typedef struct packed {
		logic [VPN_W-1:0] vpn;
	} tlb_req_t;

	typedef struct packed {
		logic [VPN_W-1:0] ppn;
		logic ok;
	} tlb_resp_t;

	// writable is kept in the layout but never checked on reads
	typedef struct packed {
		logic [APP_ID_W-1:0] app_id;
		logic [PTE_TAG_W-1:0] vpn_tag;
		logic [PTE_PPN_W-1:0] ppn;
		logic writable;
		logic present;
	} pte_t;

	// pte 0 sits in the low 64 bits of the beat
	typedef union packed {
		logic [DATA_W-1:0] data;
		pte_t [PTES_PER_LINE-1:0] ptes;
	} ret_line_u;

endpackage

// File: phys_read_arb.sv
// physical read arbiter, walker over manager on ar, id bit 0 steers returned beats
module phys_read_arb (
	input axi_tlb_pkg::ar_req_t walk_ar,
	input logic walk_ar_valid,
	output logic walk_ar_ready,
	output axi_tlb_pkg::r_beat_t walk_r,
	output logic walk_r_valid,
	input logic walk_r_ready,

	input axi_tlb_pkg::ar_req_t mgr_ar,
	input logic mgr_ar_valid,
	output logic mgr_ar_ready,
	output axi_tlb_pkg::r_beat_t mgr_r,
	output logic mgr_r_valid,
	input logic mgr_r_ready,

	output axi_tlb_pkg::ar_req_t phys_ar,
	output logic phys_ar_valid,
	input logic phys_ar_ready,
	input axi_tlb_pkg::r_beat_t phys_r,
	input logic phys_r_valid,
	output logic phys_r_ready
);

	localparam int ID_W = axi_tlb_pkg::ID_W;

	axi_tlb_pkg::r_beat_t untagged;
	logic to_mgr;

	// fixed priority, tag 0 for walker and 1 for manager
	always_comb begin
		if (walk_ar_valid) begin
			phys_ar = walk_ar;
			phys_ar.id = {walk_ar.id[ID_W-2:0], 1'b0};
		end else begin
			phys_ar = mgr_ar;
			phys_ar.id = {mgr_ar.id[ID_W-2:0], 1'b1};
		end
	end

	assign phys_ar_valid = walk_ar_valid || mgr_ar_valid;
	assign walk_ar_ready = phys_ar_ready;
	assign mgr_ar_ready = phys_ar_ready && !walk_ar_valid;

	// shift the tag back out before handing the beat on
	always_comb begin
		untagged = phys_r;
		untagged.id = {1'b0, phys_r.id[ID_W-1:1]};
	end

	assign to_mgr = phys_r.id[0];
	assign walk_r = untagged;
	assign mgr_r = untagged;
	assign walk_r_valid = phys_r_valid && !to_mgr;
	assign mgr_r_valid = phys_r_valid && to_mgr;
	assign phys_r_ready = to_mgr ? mgr_r_ready : walk_r_ready;

endmodule

// File: project.f
axi_tlb_pkg.sv
sync_fifo.sv
pte_match.sv
tlb_walker.sv
read_mgr.sv
phys_read_arb.sv
axi_tlb.sv
tb_axi_tlb.sv

// File: pte_match.sv
// pte match, checks one page-table entry against a page number and application id
module pte_match #(
	parameter logic [axi_tlb_pkg::APP_ID_W-1:0] APP_ID = '0
) (
	input axi_tlb_pkg::pte_t pte,
	input axi_tlb_pkg::tlb_req_t vpn,
	output logic hit,
	output logic [axi_tlb_pkg::VPN_W-1:0] ppn
);

	localparam int TAG_W = axi_tlb_pkg::PTE_TAG_W;
	localparam int HIGH_W = axi_tlb_pkg::VPN_W - TAG_W;

	logic tag_ok;
	logic id_ok;

	// tag covers the low page-number bits, the rest must be zero
	assign tag_ok = (pte.vpn_tag == vpn.vpn[TAG_W-1:0])
		&& (vpn.vpn[axi_tlb_pkg::VPN_W-1:TAG_W] == HIGH_W'(0));
	assign id_ok = pte.app_id == APP_ID;

	assign hit = pte.present && tag_ok && id_ok;

	// zero when missed so the walker can OR all eight together
	assign ppn = hit ? axi_tlb_pkg::VPN_W'(pte.ppn) : '0;

endmodule

// File: read_mgr.sv
// read manager, translates client reads and returns data or faults in order
module read_mgr #(
	parameter int LOG_DEPTH = 5
) (
	input logic clk,
	input logic rst,

	input axi_tlb_pkg::ar_req_t ar,
	input logic ar_valid,
	output logic ar_ready,

	output axi_tlb_pkg::r_beat_t r,
	output logic r_valid,
	input logic r_ready,

	output axi_tlb_pkg::tlb_req_t tlb_req,
	output logic tlb_req_valid,
	input logic tlb_req_ready,

	input axi_tlb_pkg::tlb_resp_t tlb_resp,
	input logic tlb_resp_valid,
	output logic tlb_resp_ready,

	output axi_tlb_pkg::ar_req_t mem_ar,
	output logic mem_ar_valid,
	input logic mem_ar_ready,

	input axi_tlb_pkg::r_beat_t mem_r,
	input logic mem_r_valid,
	output logic mem_r_ready
);

	typedef struct packed {
		logic [axi_tlb_pkg::ID_W-1:0] id;
		logic [axi_tlb_pkg::LEN_W-1:0] len;
		logic [axi_tlb_pkg::SIZE_W-1:0] size;
		logic [axi_tlb_pkg::PAGE_OFS_W-1:0] ofs;
	} req_meta_t;

	typedef struct packed {
		logic [axi_tlb_pkg::ID_W-1:0] id;
		logic ok;
	} out_meta_t;

	req_meta_t amf_data;
	req_meta_t amf_q;
	logic amf_full;
	logic amf_empty;
	logic pnf_full;
	logic pnf_empty;
	axi_tlb_pkg::tlb_resp_t paf_q;
	logic paf_full;
	logic paf_empty;
	out_meta_t omf_q;
	logic omf_full;
	logic omf_empty;
	axi_tlb_pkg::r_beat_t rrf_q;
	logic rrf_full;
	logic rrf_empty;
	logic ar_fire;
	logic join_ready;
	logic join_go;
	logic r_fire;

	// accept, split into page number and metadata
	assign ar_ready = !amf_full && !pnf_full;
	assign ar_fire = ar_valid && ar_ready;
	assign amf_data = '{id: ar.id, len: ar.len, size: ar.size,
		ofs: ar.addr[axi_tlb_pkg::PAGE_OFS_W-1:0]};

	sync_fifo #(.WIDTH($bits(req_meta_t)), .LOG_DEPTH(LOG_DEPTH)) u_meta_fifo (
		.clk(clk), .rst(rst),
		.wr_en(ar_fire), .wr_data(amf_data), .full(amf_full),
		.rd_en(join_go), .rd_data(amf_q), .empty(amf_empty)
	);

	sync_fifo #(.WIDTH($bits(axi_tlb_pkg::tlb_req_t)), .LOG_DEPTH(LOG_DEPTH)) u_vpn_fifo (
		.clk(clk), .rst(rst),
		.wr_en(ar_fire),
		.wr_data(ar.addr[axi_tlb_pkg::ADDR_W-1:axi_tlb_pkg::PAGE_OFS_W]),
		.full(pnf_full),
		.rd_en(tlb_req_valid && tlb_req_ready), .rd_data(tlb_req), .empty(pnf_empty)
	);

	assign tlb_req_valid = !pnf_empty;
	assign tlb_resp_ready = !paf_full;

	sync_fifo #(.WIDTH($bits(axi_tlb_pkg::tlb_resp_t)), .LOG_DEPTH(LOG_DEPTH)) u_xlat_fifo (
		.clk(clk), .rst(rst),
		.wr_en(tlb_resp_valid && !paf_full), .wr_data(tlb_resp), .full(paf_full),
		.rd_en(join_go), .rd_data(paf_q), .empty(paf_empty)
	);

	// join metadata with its translation, faults skip memory
	assign join_ready = !amf_empty && !paf_empty && !omf_full;
	assign mem_ar_valid = join_ready && paf_q.ok;
	assign join_go = join_ready && (!paf_q.ok || mem_ar_ready);
	assign mem_ar = '{id: '0, addr: {paf_q.ppn, amf_q.ofs}, len: amf_q.len, size: amf_q.size};

	sync_fifo #(.WIDTH($bits(out_meta_t)), .LOG_DEPTH(LOG_DEPTH)) u_out_meta_fifo (
		.clk(clk), .rst(rst),
		.wr_en(join_go), .wr_data(out_meta_t'({amf_q.id, paf_q.ok})), .full(omf_full),
		.rd_en(r_fire && (!omf_q.ok || rrf_q.last)), .rd_data(omf_q), .empty(omf_empty)
	);

	assign mem_r_ready = !rrf_full;

	sync_fifo #(.WIDTH($bits(axi_tlb_pkg::r_beat_t)), .LOG_DEPTH(LOG_DEPTH)) u_ret_fifo (
		.clk(clk), .rst(rst),
		.wr_en(mem_r_valid && !rrf_full), .wr_data(mem_r), .full(rrf_full),
		.rd_en(r_fire && omf_q.ok), .rd_data(rrf_q), .empty(rrf_empty)
	);

	// fault gives one slverr beat, data left as whatever is buffered
	assign r_valid = !omf_empty && (!omf_q.ok || !rrf_empty);
	assign r_fire = r_valid && r_ready;
	assign r = '{
		id: omf_q.id,
		data: rrf_q.data,
		resp: omf_q.ok ? rrf_q.resp : axi_tlb_pkg::RESP_SLVERR,
		last: omf_q.ok ? rrf_q.last : 1'b1
	};

	// client sees a stable valid until it takes the beat
	assert property (@(posedge clk) disable iff (rst) r_valid && !r_ready |=> r_valid)
		else $error("read_mgr: r_valid dropped without transfer");

endmodule

// File: sync_fifo.sv
// synchronous show-ahead FIFO, circular buffer with pointer and count flags
module sync_fifo #(
	parameter int WIDTH = 8,
	parameter int LOG_DEPTH = 4
) (
	input logic clk,
	input logic rst,
	input logic wr_en,
	input logic [WIDTH-1:0] wr_data,
	output logic full,
	input logic rd_en,
	output logic [WIDTH-1:0] rd_data,
	output logic empty
);

	localparam int DEPTH = 1 << LOG_DEPTH;

	logic [WIDTH-1:0] mem [DEPTH];
	logic [LOG_DEPTH-1:0] wr_ptr;
	logic [LOG_DEPTH-1:0] rd_ptr;
	logic [LOG_DEPTH:0] count;
	logic do_wr;
	logic do_rd;

	assign do_wr = wr_en && !full;
	assign do_rd = rd_en && !empty;
	assign full = count == (LOG_DEPTH + 1)'(DEPTH);
	assign empty = count == '0;
	// oldest entry is always on the output
	assign rd_data = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_wr) begin
			mem[wr_ptr] <= wr_data;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_wr) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_rd) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({do_wr, do_rd})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// callers must watch the flags
	assert property (@(posedge clk) disable iff (rst) !(wr_en && full))
		else $error("sync_fifo: write while full");
	assert property (@(posedge clk) disable iff (rst) !(rd_en && empty))
		else $error("sync_fifo: read while empty");

endmodule

// File: tb_axi_tlb.sv
// axi tlb testbench, random reads against a page-table and memory model with in-order checks
module tb_axi_tlb;

	localparam int N_REQ = 200;
	localparam int NPAGE = 8;
	localparam int VPN_BASE = 'h100;
	localparam int TIMEOUT_CYCLES = 400 * N_REQ;

	logic clk;
	logic rst;
	axi_tlb_pkg::ar_req_t ar;
	logic ar_valid;
	logic ar_ready;
	axi_tlb_pkg::r_beat_t r;
	logic r_valid;
	logic r_ready;
	axi_tlb_pkg::ar_req_t phys_ar;
	logic phys_ar_valid;
	logic phys_ar_ready;
	axi_tlb_pkg::r_beat_t phys_r;
	logic phys_r_valid;
	logic phys_r_ready;

	logic [15:0] lfsr;
	int error_count;
	int check_count;
	int req_idx;
	int done_count;
	int cycles;

	// page table and reference state
	logic [axi_tlb_pkg::VPN_W-1:0] page_vpn [NPAGE];
	logic [23:0] page_ppn [NPAGE];
	logic page_hit [NPAGE];
	logic [axi_tlb_pkg::DATA_W-1:0] page_line [NPAGE];
	axi_tlb_pkg::r_beat_t exp_beat_q [$];
	axi_tlb_pkg::ar_req_t exp_walk_q [$];
	axi_tlb_pkg::ar_req_t exp_mgr_q [$];

	// stimulus and memory model state
	axi_tlb_pkg::ar_req_t cur_req;
	int cur_page;
	logic ar_pending;
	axi_tlb_pkg::ar_req_t mem_q [$];
	logic [7:0] mem_beat;
	logic mem_presenting;

	axi_tlb #(.APP_ID(2'd1), .LOG_DEPTH(5)) DUT (
		.clk(clk), .rst(rst),
		.ar(ar), .ar_valid(ar_valid), .ar_ready(ar_ready),
		.r(r), .r_valid(r_valid), .r_ready(r_ready),
		.phys_ar(phys_ar), .phys_ar_valid(phys_ar_valid), .phys_ar_ready(phys_ar_ready),
		.phys_r(phys_r), .phys_r_valid(phys_r_valid), .phys_r_ready(phys_r_ready)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// 16-bit fibonacci lfsr, taps 16 14 13 11
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		logic fb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
			lfsr = {lfsr[14:0], fb};
			v = {v[30:0], fb};
		end
		return v;
	endfunction

	// data page contents, every word depends on address and beat
	function automatic logic [axi_tlb_pkg::DATA_W-1:0] beat_data(input logic [63:0] addr,
		input logic [7:0] beat);
		logic [axi_tlb_pkg::DATA_W-1:0] d;
		for (int k = 0; k < 8; k++) begin
			d[k*64 +: 64] = addr ^ {48'h5a5a_0000_0000, beat, 8'(k)};
		end
		return d;
	endfunction

	function automatic logic [axi_tlb_pkg::DATA_W-1:0] table_data(input logic [63:0] addr);
		int idx;
		idx = int'(addr[34:6]) - VPN_BASE;
		if (idx >= 0 && idx < NPAGE) begin
			return page_line[idx];
		end
		return '0;
	endfunction

	// one mapping per page line, the other seven slots hold decoys
	task build_page_table();
		axi_tlb_pkg::pte_t pte;
		axi_tlb_pkg::pte_t decoy;
		axi_tlb_pkg::ret_line_u line;
		int kind;
		for (int p = 0; p < NPAGE; p++) begin
			page_vpn[p] = 52'(VPN_BASE + p);
			page_ppn[p] = 24'h800000 + 24'(p * 'h35);
			kind = (p >= 4 && p <= 6) ? p - 3 : 0;
			pte.app_id = 2'd1;
			pte.vpn_tag = page_vpn[p][35:0];
			pte.ppn = page_ppn[p];
			pte.writable = 1'b0;
			pte.present = 1'b1;
			case (kind)
				1: pte.app_id = 2'd2;
				2: pte.present = 1'b0;
				3: pte.vpn_tag = page_vpn[p][35:0] ^ 36'h1;
				default: pte.present = 1'b1;
			endcase
			page_hit[p] = kind == 0;
			for (int s = 0; s < 8; s++) begin
				decoy.app_id = 2'd1;
				decoy.vpn_tag = page_vpn[p][35:0] + 36'(s * 'h1000 + 'h40);
				decoy.ppn = 24'(rand_bits(24));
				decoy.writable = 1'b1;
				decoy.present = 1'b1;
				line.ptes[s] = (s == (p * 3) % 8) ? pte : decoy;
			end
			page_line[p] = line.data;
		end
	endtask

	task check_beat(input axi_tlb_pkg::r_beat_t got, input axi_tlb_pkg::r_beat_t exp);
		logic data_ok;
		check_count++;
		data_ok = exp.resp != axi_tlb_pkg::RESP_OKAY || got.data === exp.data;
		if (got.id !== exp.id || got.resp !== exp.resp || got.last !== exp.last || !data_ok) begin
			error_count++;
			$display("FAIL %0t: beat id %h resp %b last %b data ok %b, expected id %h resp %b last %b",
				$time, got.id, got.resp, got.last, data_ok, exp.id, exp.resp, exp.last);
		end
	endtask

	task check_phys_ar(input axi_tlb_pkg::ar_req_t got, input axi_tlb_pkg::ar_req_t exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("FAIL %0t: phys ar id %h addr %h len %0d size %0d, expected %h %h %0d %0d",
				$time, got.id, got.addr, got.len, got.size, exp.id, exp.addr, exp.len, exp.size);
		end
	endtask

	task check_flag(input string name, input logic got, input logic exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("FAIL %0t: %s is %b, expected %b", $time, name, got, exp);
		end
	endtask

	// reference model, expected walker read, data read and client beats
	task accept_request(input axi_tlb_pkg::ar_req_t req, input int p);
		axi_tlb_pkg::ar_req_t pa;
		axi_tlb_pkg::r_beat_t b;
		logic [63:0] phys_addr;
		pa.id = 16'h0;
		pa.addr = {35'h0, page_vpn[p][22:0], 6'h0};
		pa.len = 8'h0;
		pa.size = axi_tlb_pkg::PTE_LINE_SIZE;
		exp_walk_q.push_back(pa);
		b.id = req.id;
		if (page_hit[p]) begin
			phys_addr = {28'h0, page_ppn[p], req.addr[11:0]};
			pa.id = 16'h1;
			pa.addr = phys_addr;
			pa.len = req.len;
			pa.size = req.size;
			exp_mgr_q.push_back(pa);
			for (int k = 0; k <= int'(req.len); k++) begin
				b.data = beat_data(phys_addr, 8'(k));
				b.resp = axi_tlb_pkg::RESP_OKAY;
				b.last = k == int'(req.len);
				exp_beat_q.push_back(b);
			end
		end else begin
			b.data = '0;
			b.resp = axi_tlb_pkg::RESP_SLVERR;
			b.last = 1'b1;
			exp_beat_q.push_back(b);
		end
	endtask

	task drive_inputs();
		if (!ar_pending && req_idx < N_REQ && rand_bits(2) != 0) begin
			cur_page = int'(rand_bits(3));
			cur_req.id = 16'(rand_bits(16));
			cur_req.addr = {page_vpn[cur_page], 12'(rand_bits(12))};
			cur_req.len = 8'(rand_bits(3));
			cur_req.size = 3'(rand_bits(3));
			ar_pending = 1'b1;
		end
		ar = cur_req;
		ar_valid = ar_pending;
		// heavy back-pressure in the first half
		r_ready = (req_idx < N_REQ / 2) ? (rand_bits(2) == 0) : (rand_bits(2) != 0);
		phys_ar_ready = rand_bits(2) != 0;
		if (!mem_presenting && mem_q.size() > 0 && rand_bits(2) != 0) begin
			mem_presenting = 1'b1;
		end
		phys_r_valid = mem_presenting;
		if (mem_presenting) begin
			phys_r.id = mem_q[0].id;
			phys_r.resp = axi_tlb_pkg::RESP_OKAY;
			phys_r.last = mem_beat == mem_q[0].len;
			phys_r.data = (mem_q[0].addr[63:35] == '0) ? table_data(mem_q[0].addr)
				: beat_data(mem_q[0].addr, mem_beat);
		end
	endtask

	// handshakes seen here fire at the coming rising edge
	task sample_outputs();
		axi_tlb_pkg::r_beat_t exp;
		if (ar_valid && ar_ready) begin
			accept_request(cur_req, cur_page);
			ar_pending = 1'b0;
			req_idx++;
		end
		if (phys_ar_valid && phys_ar_ready) begin
			mem_q.push_back(phys_ar);
			if (phys_ar.id[0] && exp_mgr_q.size() == 0) begin
				error_count++;
				$display("data read to %h issued with no translated request waiting", phys_ar.addr);
			end else if (!phys_ar.id[0] && exp_walk_q.size() == 0) begin
				error_count++;
				$display("table read to %h issued with no request waiting", phys_ar.addr);
			end else if (phys_ar.id[0]) begin
				check_phys_ar(phys_ar, exp_mgr_q.pop_front());
			end else begin
				check_phys_ar(phys_ar, exp_walk_q.pop_front());
			end
		end
		if (phys_r_valid && phys_r_ready) begin
			if (phys_r.last) begin
				void'(mem_q.pop_front());
				mem_beat = 8'h0;
			end else begin
				mem_beat = mem_beat + 8'h1;
			end
			mem_presenting = 1'b0;
		end
		if (r_valid && r_ready) begin
			if (exp_beat_q.size() == 0) begin
				error_count++;
				$display("client beat with id %h arrived with nothing outstanding", r.id);
			end else begin
				exp = exp_beat_q.pop_front();
				check_beat(r, exp);
				if (exp.last) begin
					done_count++;
				end
			end
		end
	endtask

	initial begin : watchdog
		cycles = 0;
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout after %0d cycles with %0d of %0d requests complete",
			cycles, done_count, N_REQ);
		$display("checks %0d errors %0d", check_count, error_count);
		$display("*** FAILED ***");
		$finish;
	end

	initial begin : main
		int drain;
		lfsr = 16'd19938;
		rst = 1'b1;
		ar = '0;
		ar_valid = 1'b0;
		r_ready = 1'b0;
		phys_ar_ready = 1'b0;
		phys_r = '0;
		phys_r_valid = 1'b0;
		error_count = 0;
		check_count = 0;
		req_idx = 0;
		done_count = 0;
		cur_req = '0;
		cur_page = 0;
		ar_pending = 1'b0;
		mem_beat = 8'h0;
		mem_presenting = 1'b0;
		drain = 0;
		build_page_table();
		repeat (10) @(posedge clk);
		#1 rst = 1'b0;
		@(negedge clk);
		check_flag("r_valid", r_valid, 1'b0);
		check_flag("phys_ar_valid", phys_ar_valid, 1'b0);
		check_flag("ar_ready", ar_ready, 1'b1);
		// keep running a little past the last beat to catch extras
		while (drain < 20) begin
			@(posedge clk);
			#1 drive_inputs();
			@(negedge clk);
			sample_outputs();
			if (done_count == N_REQ) begin
				drain++;
			end
		end
		if (exp_beat_q.size() != 0 || exp_walk_q.size() != 0 || exp_mgr_q.size() != 0
			|| mem_q.size() != 0) begin
			error_count++;
			$display("work left over at the end: %0d beats %0d table reads %0d data reads",
				exp_beat_q.size(), exp_walk_q.size(), exp_mgr_q.size());
		end
		$display("checks %0d errors %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

// File: tlb_walker.sv
// tlb walker, fetches one pte line per request and matches its eight entries
module tlb_walker #(
	parameter logic [axi_tlb_pkg::APP_ID_W-1:0] APP_ID = '0,
	parameter int LOG_DEPTH = 5
) (
	input logic clk,
	input logic rst,

	input axi_tlb_pkg::tlb_req_t tlb_req,
	input logic tlb_req_valid,
	output logic tlb_req_ready,

	output axi_tlb_pkg::tlb_resp_t tlb_resp,
	output logic tlb_resp_valid,
	input logic tlb_resp_ready,

	output axi_tlb_pkg::ar_req_t pte_ar,
	output logic pte_ar_valid,
	input logic pte_ar_ready,

	input axi_tlb_pkg::r_beat_t pte_r,
	input logic pte_r_valid,
	output logic pte_r_ready
);

	localparam int NPTE = axi_tlb_pkg::PTES_PER_LINE;
	localparam int LINE_IDX_W = 23;
	localparam int LINE_OFS_W = 6;
	localparam int ADDR_PAD_W = axi_tlb_pkg::ADDR_W - LINE_IDX_W - LINE_OFS_W;

	axi_tlb_pkg::tlb_req_t vpn_q;
	logic vpnf_full;
	logic vpnf_empty;
	logic [axi_tlb_pkg::ADDR_W-1:0] ptaf_data;
	logic [axi_tlb_pkg::ADDR_W-1:0] ptaf_q;
	logic ptaf_full;
	logic ptaf_empty;
	axi_tlb_pkg::ret_line_u line;
	logic linef_full;
	logic linef_empty;
	logic req_fire;
	logic resp_fire;
	logic [NPTE-1:0] hits;
	logic [axi_tlb_pkg::VPN_W-1:0] ppns [NPTE];
	logic [axi_tlb_pkg::VPN_W-1:0] merged_ppn;

	// request side, page number and line address queued together
	assign tlb_req_ready = !vpnf_full && !ptaf_full;
	assign req_fire = tlb_req_valid && tlb_req_ready;
	assign ptaf_data = {ADDR_PAD_W'(0), tlb_req.vpn[LINE_IDX_W-1:0], LINE_OFS_W'(0)};

	sync_fifo #(.WIDTH($bits(axi_tlb_pkg::tlb_req_t)), .LOG_DEPTH(LOG_DEPTH)) u_vpn_fifo (
		.clk(clk), .rst(rst),
		.wr_en(req_fire), .wr_data(tlb_req), .full(vpnf_full),
		.rd_en(resp_fire), .rd_data(vpn_q), .empty(vpnf_empty)
	);

	sync_fifo #(.WIDTH(axi_tlb_pkg::ADDR_W), .LOG_DEPTH(LOG_DEPTH)) u_pte_addr_fifo (
		.clk(clk), .rst(rst),
		.wr_en(req_fire), .wr_data(ptaf_data), .full(ptaf_full),
		.rd_en(pte_ar_valid && pte_ar_ready), .rd_data(ptaf_q), .empty(ptaf_empty)
	);

	// single-beat line read
	assign pte_ar = '{id: '0, addr: ptaf_q, len: '0, size: axi_tlb_pkg::PTE_LINE_SIZE};
	assign pte_ar_valid = !ptaf_empty;

	assign pte_r_ready = !linef_full;

	sync_fifo #(.WIDTH(axi_tlb_pkg::DATA_W), .LOG_DEPTH(LOG_DEPTH)) u_line_fifo (
		.clk(clk), .rst(rst),
		.wr_en(pte_r_valid && !linef_full), .wr_data(pte_r.data), .full(linef_full),
		.rd_en(resp_fire), .rd_data(line), .empty(linef_empty)
	);

	for (genvar g = 0; g < NPTE; g++) begin : g_match
		pte_match #(.APP_ID(APP_ID)) u_match (
			.pte(line.ptes[g]),
			.vpn(vpn_q),
			.hit(hits[g]),
			.ppn(ppns[g])
		);
	end

	always_comb begin
		merged_ppn = '0;
		for (int i = 0; i < NPTE; i++) begin
			merged_ppn |= ppns[i];
		end
	end

	// lines return in request order, so the heads pair up
	assign tlb_resp = '{ppn: merged_ppn, ok: |hits};
	assign tlb_resp_valid = !vpnf_empty && !linef_empty;
	assign resp_fire = tlb_resp_valid && tlb_resp_ready;

	// a well-formed table never maps a page twice in one line
	assert property (@(posedge clk) disable iff (rst) tlb_resp_valid |-> $onehot0(hits))
		else $error("tlb_walker: more than one pte hit");

endmodule
